//--- hw/led_pkg.sv
// Shared constants for the front-panel LED subsystem
// ms_div is shortened for simulation; real builds change it only here
// num_slots must equal 2**slot_id_w so every slot number is valid

package led_pkg;

    // ------------------------------
    // Slot geometry
    // ------------------------------
    // Line slots, one two-colour LED each
    localparam int num_slots = 4;
    // Width of a slot number on the frame-status strobe
    localparam int slot_id_w = 2;
    // Pins per LED and total pin vector width
    localparam int led_w     = 2;
    localparam int pin_w     = num_slots * led_w;

    // ------------------------------
    // Time base
    // ------------------------------
    // clk_sys cycles per millisecond enable
    localparam int ms_div    = 50;
    // Down-counter width for the divider
    localparam int ms_cnt_w  = $clog2(ms_div);

    // ------------------------------
    // Per-slot controller
    // ------------------------------
    // Good-frame counter, saturating
    localparam int cnt_w     = 5;
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(31);
    // Error delay line depth, at least 2
    localparam int err_delay = 3;

    // Bit positions within one slot's LED pair
    localparam int led_grn   = 0;
    localparam int led_red   = 1;

endpackage

//--- hw/slot_led_if.sv
// Per-slot bundle between the event router and one LED controller
// All router-side fields are registered; led is registered in the controller

interface slot_led_if;

    // Millisecond enable, realigned by the router
    logic                      ms_en;
    // Configuration enable for this slot
    logic                      cfg_en;
    // Slot present
    logic                      slot_en;
    // One-cycle good frame pulse
    logic                      eop_ok;
    // One-cycle erroring frame pulse
    logic                      err;
    // LED pair, green at led_grn, red at led_red
    logic [led_pkg::led_w-1:0] led;

    // Router side drives the triggers and enables
    modport router (
        output ms_en,
        output cfg_en,
        output slot_en,
        output eop_ok,
        output err
    );

    // Controller side consumes them and owns the LED state
    modport ctl (
        input  ms_en,
        input  cfg_en,
        input  slot_en,
        input  eop_ok,
        input  err,
        output led
    );

endinterface

//--- hw/ms_tick_gen.sv
// Millisecond enable generator, one-cycle pulse every led_pkg::ms_div cycles
// First pulse ms_div cycles after reset release

module ms_tick_gen (
    input  logic clk_sys,
    input  logic rst_sys_n,
    output logic ms_en
);

    // ------------------------------
    // Divider
    // ------------------------------
    logic [led_pkg::ms_cnt_w-1:0] div_cnt;
    logic                         div_zero;

    // Terminal count
    assign div_zero = (div_cnt == '0);

    // Down-counter, reload on zero
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            div_cnt <= led_pkg::ms_cnt_w'(led_pkg::ms_div - 1);
        end else if (div_zero) begin
            div_cnt <= led_pkg::ms_cnt_w'(led_pkg::ms_div - 1);
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // Pulse in the cycle the counter has just reloaded
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            ms_en <= 1'b0;
        end else begin
            ms_en <= div_zero;
        end
    end

endmodule

//--- hw/event_router.sv
// Decodes the shared frame-status strobe into per-slot triggers
// One cycle latency on every output, including the forwarded ms_en
// Strobes are consumed in the cycle they appear; there is no back-pressure

module event_router (
    input  logic                           clk_sys,
    input  logic                           rst_sys_n,
    input  logic                           ms_en,
    input  logic                           frame_done,
    input  logic [led_pkg::slot_id_w-1:0]  frame_slot,
    input  logic                           frame_err,
    input  logic [led_pkg::num_slots-1:0]  cfg_en_mask,
    input  logic [led_pkg::num_slots-1:0]  slot_present,
    slot_led_if.router                     slot [led_pkg::num_slots]
);

    // ------------------------------
    // Slot decode
    // ------------------------------
    // One-hot slot select, only while a frame completes
    logic [led_pkg::num_slots-1:0] slot_hit;

    always_comb begin
        slot_hit = '0;
        if (frame_done) begin
            slot_hit[frame_slot] = 1'b1;
        end
    end

    // ------------------------------
    // Per-slot output registers
    // ------------------------------
    for (genvar i = 0; i < led_pkg::num_slots; i++) begin : g_slot

        // Tick copied per slot so it stays aligned with the triggers
        always_ff @(posedge clk_sys or negedge rst_sys_n) begin
            if (!rst_sys_n) begin
                slot[i].ms_en <= 1'b0;
            end else begin
                slot[i].ms_en <= ms_en;
            end
        end

        // Good and erroring frame classification
        always_ff @(posedge clk_sys or negedge rst_sys_n) begin
            if (!rst_sys_n) begin
                slot[i].eop_ok <= 1'b0;
                slot[i].err    <= 1'b0;
            end else begin
                slot[i].eop_ok <= slot_hit[i] & ~frame_err;
                slot[i].err    <= slot_hit[i] & frame_err;
            end
        end

        // Mask levels, registered for alignment
        always_ff @(posedge clk_sys or negedge rst_sys_n) begin
            if (!rst_sys_n) begin
                slot[i].cfg_en  <= 1'b0;
                slot[i].slot_en <= 1'b0;
            end else begin
                slot[i].cfg_en  <= cfg_en_mask[i];
                slot[i].slot_en <= slot_present[i];
            end
        end

    end

endmodule

//--- hw/com_led_ctl.sv
// One slot's LED controller: green blinks on good traffic, red flags errors
// Red follows err after led_pkg::err_delay + 1 cycles
// Green only changes state at an ms_en edge, except when forced low

module com_led_ctl (
    input  logic    clk_sys,
    input  logic    rst_sys_n,
    slot_led_if.ctl slot
);

    // Both enables must be up for any LED to light
    logic                      slot_on;
    // Saturating good-frame count within the current period
    logic [led_pkg::cnt_w-1:0] eop_cnt;
    // Error delay line, oldest stage at the top
    logic [led_pkg::err_delay-1:0] err_dly;
    // Red state for the next cycle
    logic                      red_nxt;

    assign slot_on = slot.cfg_en & slot.slot_en;
    assign red_nxt = err_dly[led_pkg::err_delay-1] & slot_on;

    // ------------------------------
    // Good-frame counter
    // ------------------------------
    // Clear on tick wins over a same-cycle frame
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            eop_cnt <= '0;
        end else if (slot.ms_en) begin
            eop_cnt <= '0;
        end else if (slot.eop_ok && (eop_cnt != led_pkg::cnt_max)) begin
            eop_cnt <= eop_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Green LED
    // ------------------------------
    // Keyed to red_nxt so green drops in the same cycle red lights
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            slot.led[led_pkg::led_grn] <= 1'b0;
        end else if (!slot_on || red_nxt) begin
            slot.led[led_pkg::led_grn] <= 1'b0;
        end else if (slot.ms_en) begin
            // Toggle on activity, go dark on a silent period
            if (eop_cnt != '0) begin
                slot.led[led_pkg::led_grn] <= ~slot.led[led_pkg::led_grn];
            end else begin
                slot.led[led_pkg::led_grn] <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Red LED
    // ------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            err_dly <= '0;
        end else begin
            err_dly <= {err_dly[led_pkg::err_delay-2:0], slot.err};
        end
    end

    // One lit cycle per erroring frame
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            slot.led[led_pkg::led_red] <= 1'b0;
        end else begin
            slot.led[led_pkg::led_red] <= red_nxt;
        end
    end

endmodule

//--- hw/led_driver.sv
// Pin driver: packs all slot LED pairs and registers them for the pads
// Slot i green on pin 2i, red on pin 2i+1
// Lamp test forces every pin high one cycle after it rises

module led_driver (
    input  logic                      clk_sys,
    input  logic                      rst_sys_n,
    input  logic                      lamp_test,
    slot_led_if.ctl                   slot [led_pkg::num_slots],
    output logic [led_pkg::pin_w-1:0] led_pins
);

    // Unregistered pin image
    logic [led_pkg::pin_w-1:0] pins_nxt;

    // ------------------------------
    // Packing
    // ------------------------------
    // Only the led field is read here
    for (genvar i = 0; i < led_pkg::num_slots; i++) begin : g_pack
        assign pins_nxt[led_pkg::led_w*i + led_pkg::led_grn] =
            slot[i].led[led_pkg::led_grn];
        assign pins_nxt[led_pkg::led_w*i + led_pkg::led_red] =
            slot[i].led[led_pkg::led_red];
    end

    // ------------------------------
    // Output register
    // ------------------------------
    // Lamp test ORed over all pins
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            led_pins <= '0;
        end else begin
            led_pins <= pins_nxt | {led_pkg::pin_w{lamp_test}};
        end
    end

endmodule

//--- hw/slot_led_top.sv
// Front-panel LED subsystem top, plain ports only
// Frame error to red pin is 6 cycles; mask clear to dark pins is 3 cycles
// Single clock domain, no bus interface

module slot_led_top (
    input  logic                           clk_sys,
    input  logic                           rst_sys_n,
    // Frame-status strobe, one per completed frame
    input  logic                           frame_done,
    input  logic [led_pkg::slot_id_w-1:0]  frame_slot,
    input  logic                           frame_err,
    // Static configuration levels
    input  logic [led_pkg::num_slots-1:0]  cfg_en_mask,
    input  logic [led_pkg::num_slots-1:0]  slot_present,
    input  logic                           lamp_test,
    // Pad outputs
    output logic [led_pkg::pin_w-1:0]      led_pins
);

    // Common millisecond enable
    logic ms_en;

    // One bundle per slot
    slot_led_if slot_if [led_pkg::num_slots] ();

    // ------------------------------
    // Time base and routing
    // ------------------------------
    ms_tick_gen u_ms_tick_gen (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .ms_en     (ms_en)
    );

    event_router u_event_router (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .ms_en        (ms_en),
        .frame_done   (frame_done),
        .frame_slot   (frame_slot),
        .frame_err    (frame_err),
        .cfg_en_mask  (cfg_en_mask),
        .slot_present (slot_present),
        .slot         (slot_if)
    );

    // ------------------------------
    // Per-slot controllers
    // ------------------------------
    for (genvar i = 0; i < led_pkg::num_slots; i++) begin : u_ctl
        com_led_ctl u_com_led_ctl (
            .clk_sys   (clk_sys),
            .rst_sys_n (rst_sys_n),
            .slot      (slot_if[i])
        );
    end

    // ------------------------------
    // Pad driver
    // ------------------------------
    led_driver u_led_driver (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .lamp_test (lamp_test),
        .slot      (slot_if),
        .led_pins  (led_pins)
    );

endmodule

//--- sim/slot_led_chk.sv
// Assertions bound into slot_led_top: reset state, lamp test, red/green exclusion
// The bind below lists four slot bundles, one per led_pkg::num_slots

module slot_led_chk (
    input logic                      clk_sys,
    input logic                      rst_sys_n,
    input logic                      lamp_test,
    input logic [led_pkg::pin_w-1:0] led_pins,
    // Controller LED pairs, slot 0 in the low bits
    input logic [led_pkg::pin_w-1:0] led_pairs
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertion count
    int fail_count = 0;

    // ------------------------------
    // Reset state
    // ------------------------------
    a_reset_dark: assert property (@(posedge clk_sys) !rst_sys_n |-> (led_pins == '0))
        else begin
            $error("led_pins not dark during reset");
            fail_count++;
        end

    // First registered value after release
    a_release_dark: assert property (@(posedge clk_sys)
        ($rose(rst_sys_n) && !lamp_test) |=> (led_pins == '0))
        else begin
            $error("led_pins not dark one cycle after reset release");
            fail_count++;
        end

    // ------------------------------
    // Lamp test
    // ------------------------------
    a_lamp_test: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        lamp_test |=> (&led_pins))
        else begin
            $error("lamp test did not light every pin");
            fail_count++;
        end

    // Red and green never lit together in one controller
    for (genvar i = 0; i < led_pkg::num_slots; i++) begin : g_excl
        a_red_grn: assert property (@(posedge clk_sys)
            !(led_pairs[led_pkg::led_w*i + led_pkg::led_grn] &&
              led_pairs[led_pkg::led_w*i + led_pkg::led_red]))
            else begin
                $error("slot %0d has red and green lit together", i);
                fail_count++;
            end
    end

endmodule

bind slot_led_top slot_led_chk u_chk (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .lamp_test (lamp_test),
    .led_pins  (led_pins),
    .led_pairs ({slot_if[3].led, slot_if[2].led, slot_if[1].led, slot_if[0].led})
);

//--- sim/slot_led_tb.sv
// Random testbench for slot_led_top, checked every cycle against a model of the LED rules
// led_pins and each controller's LED pair are compared at every falling edge
// Fixed seed, so a failing run repeats exactly

module slot_led_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // Run length
    // ------------------------------
    localparam int clk_period_ns = 4;
    // Millisecond periods summed over all phases
    localparam int total_periods = 40;
    localparam int limit_ns      = (total_periods * led_pkg::ms_div + 200) * clk_period_ns;

    // DUT ports
    logic                          clk_sys;
    logic                          rst_sys_n;
    logic                          frame_done;
    logic [led_pkg::slot_id_w-1:0] frame_slot;
    logic                          frame_err;
    logic [led_pkg::num_slots-1:0] cfg_en_mask;
    logic [led_pkg::num_slots-1:0] slot_present;
    logic                          lamp_test;
    logic [led_pkg::pin_w-1:0]     led_pins;

    // Model state: divider, router registers, controllers, pad register
    int                            m_cyc;
    logic                          m_tick;
    logic                          m_r_ms;
    logic [led_pkg::num_slots-1:0] m_r_ok;
    logic [led_pkg::num_slots-1:0] m_r_err;
    logic [led_pkg::num_slots-1:0] m_r_cfg;
    logic [led_pkg::num_slots-1:0] m_r_pres;
    int                            m_cnt [led_pkg::num_slots];
    logic [led_pkg::num_slots-1:0] m_grn;
    logic [led_pkg::num_slots-1:0] m_red;
    logic [led_pkg::err_delay-1:0] m_dly [led_pkg::num_slots];
    logic [led_pkg::pin_w-1:0]     exp_pins;

    slot_led_top UUT (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .frame_done   (frame_done),
        .frame_slot   (frame_slot),
        .frame_err    (frame_err),
        .cfg_en_mask  (cfg_en_mask),
        .slot_present (slot_present),
        .lamp_test    (lamp_test),
        .led_pins     (led_pins)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(clk_period_ns / 2) clk_sys = ~clk_sys;
    end

    // ------------------------------
    // Cycle model
    // ------------------------------
    task automatic clear_model();
        m_cyc    = 0;
        m_tick   = 1'b0;
        m_r_ms   = 1'b0;
        m_r_ok   = '0;
        m_r_err  = '0;
        m_r_cfg  = '0;
        m_r_pres = '0;
        m_grn    = '0;
        m_red    = '0;
        exp_pins = '0;
        for (int i = 0; i < led_pkg::num_slots; i++) begin
            m_cnt[i] = 0;
            m_dly[i] = '0;
        end
    endtask

    // Stages updated back to front, so each one reads last cycle's values
    task automatic step_model();
        logic on;
        logic red_n;
        logic hit;
        // Pad register with lamp test over every pin
        for (int i = 0; i < led_pkg::num_slots; i++) begin
            exp_pins[led_pkg::led_w*i + led_pkg::led_grn] = m_grn[i] | lamp_test;
            exp_pins[led_pkg::led_w*i + led_pkg::led_red] = m_red[i] | lamp_test;
        end
        for (int i = 0; i < led_pkg::num_slots; i++) begin
            on    = m_r_cfg[i] & m_r_pres[i];
            red_n = m_dly[i][led_pkg::err_delay-1] & on;
            // Green dark while disabled or red lit, else acts only on the tick
            if (!on || red_n) begin
                m_grn[i] = 1'b0;
            end else if (m_r_ms) begin
                m_grn[i] = (m_cnt[i] != 0) ? ~m_grn[i] : 1'b0;
            end
            m_red[i] = red_n;
            m_dly[i] = {m_dly[i][led_pkg::err_delay-2:0], m_r_err[i]};
            // Count saturates at cnt_max, tick clears it
            if (m_r_ms) begin
                m_cnt[i] = 0;
            end else if (m_r_ok[i] && (m_cnt[i] < int'(led_pkg::cnt_max))) begin
                m_cnt[i] = m_cnt[i] + 1;
            end
        end
        // Router
        for (int i = 0; i < led_pkg::num_slots; i++) begin
            hit         = frame_done && (frame_slot == i);
            m_r_ok[i]   = hit && !frame_err;
            m_r_err[i]  = hit && frame_err;
            m_r_cfg[i]  = cfg_en_mask[i];
            m_r_pres[i] = slot_present[i];
        end
        m_r_ms = m_tick;
        // Tick ms_div edges after reset release, then every ms_div edges
        m_cyc  = m_cyc + 1;
        m_tick = ((m_cyc % led_pkg::ms_div) == 0);
    endtask

    always @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            clear_model();
        end else begin
            step_model();
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_pair(input int slot, input logic [led_pkg::led_w-1:0] exp,
                              input logic [led_pkg::led_w-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns UUT.slot_if[%0d].led expected %b actual %b",
                     $time, slot, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pins(input logic [led_pkg::pin_w-1:0] exp,
                              input logic [led_pkg::pin_w-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0d ns led_pins expected %b actual %b", $time, exp, act);
            abort_run();
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk_sys) begin
        check_pins(exp_pins, led_pins);
    end

    // Controller pairs seen directly, so lamp test cannot hide them
    for (genvar g = 0; g < led_pkg::num_slots; g++) begin : g_pair_chk
        logic [led_pkg::led_w-1:0] exp_pair;

        assign exp_pair[led_pkg::led_grn] = m_grn[g];
        assign exp_pair[led_pkg::led_red] = m_red[g];

        always @(negedge clk_sys) begin
            check_pair(g, exp_pair, UUT.slot_if[g].led);
        end
    end

    // Bound checker failures end the run at once
    always @(UUT.u_chk.fail_count) begin
        if (UUT.u_chk.fail_count != 0) begin
            $display("Assertion failure reported by slot_led_chk");
            abort_run();
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Percent for frames and errors, per mille for mask changes and lamp pulses
    task automatic run_phase(input int periods, input int done_pct, input int err_pct,
                             input int fixed_slot, input int mask_pm, input int lamp_pm);
        for (int n = 0; n < periods * led_pkg::ms_div; n++) begin
            @(posedge clk_sys);
            frame_done <= ($urandom_range(99) < done_pct);
            frame_err  <= ($urandom_range(99) < err_pct);
            if (fixed_slot < 0) begin
                frame_slot <= led_pkg::slot_id_w'($urandom_range(led_pkg::num_slots - 1));
            end else begin
                frame_slot <= led_pkg::slot_id_w'(fixed_slot);
            end
            if ($urandom_range(999) < mask_pm) begin
                cfg_en_mask  <= led_pkg::num_slots'($urandom);
                slot_present <= led_pkg::num_slots'($urandom);
            end
            lamp_test <= ($urandom_range(999) < lamp_pm);
        end
    endtask

    // Exactly burst_len good frames to one slot at the start of every period
    task automatic send_burst(input int periods, input int slot, input int burst_len);
        for (int n = 0; n < periods * led_pkg::ms_div; n++) begin
            @(posedge clk_sys);
            frame_done <= ((n % led_pkg::ms_div) < burst_len);
            frame_err  <= 1'b0;
            frame_slot <= led_pkg::slot_id_w'(slot);
            lamp_test  <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(59));
        rst_sys_n    = 1'b1;
        frame_done   = 1'b0;
        frame_slot   = '0;
        frame_err    = 1'b0;
        cfg_en_mask  = '1;
        slot_present = '1;
        lamp_test    = 1'b0;
        // Clean reset edge ahead of the first clock
        #1;
        rst_sys_n = 1'b0;
        repeat (2) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
        // Idle, light good traffic, full-rate traffic on slot 2
        run_phase(4, 0, 0, -1, 0, 0);
        run_phase(8, 20, 0, -1, 0, 0);
        run_phase(2, 100, 0, 2, 0, 0);
        // One frame past cnt_max per period, a wrapping count would read zero
        send_burst(2, 2, int'(led_pkg::cnt_max) + 1);
        // Errors among good traffic
        run_phase(8, 30, 25, -1, 0, 0);
        // Mask churn under traffic
        run_phase(8, 40, 15, -1, 30, 0);
        cfg_en_mask  <= '1;
        slot_present <= '1;
        // Lamp test pulses over running traffic
        run_phase(8, 30, 10, -1, 0, 60);
        frame_done <= 1'b0;
        lamp_test  <= 1'b0;
        repeat (10) @(posedge clk_sys);
        if (UUT.u_chk.fail_count != 0) begin
            $display("%0d assertion failures in slot_led_chk", UUT.u_chk.fail_count);
            $display("FAIL: see errors above");
            $fatal(1);
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(limit_ns);
        $display("Timeout: the test sequence did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

//--- all.f
hw/led_pkg.sv
hw/slot_led_if.sv
hw/ms_tick_gen.sv
hw/event_router.sv
hw/com_led_ctl.sv
hw/led_driver.sv
hw/slot_led_top.sv
sim/slot_led_chk.sv
sim/slot_led_tb.sv

//--- Bender.yml
package:
  name: slot_led

dependencies: {}

sources:
  # RTL, package and interface first
  - hw/led_pkg.sv
  - hw/slot_led_if.sv
  - hw/ms_tick_gen.sv
  - hw/event_router.sv
  - hw/com_led_ctl.sv
  - hw/led_driver.sv
  - hw/slot_led_top.sv

  # Simulation only
  - target: simulation
    files:
      - sim/slot_led_chk.sv
      - sim/slot_led_tb.sv
